//--- logic/eth_tx_pkg.sv
package eth_tx_pkg;

	////////////////////
	// Transmit data types

	// One 32-bit word as it leaves on the MAC bus
	typedef logic [31:0] word_t;

	// Valid bytes in one word, 0 to 4
	typedef logic [2:0] byte_cnt_t;

	// Frame length in bytes as the host writes it
	typedef logic [10:0] frame_len_t;

	// Frame length in whole words, rounded up
	typedef logic [9:0] word_cnt_t;

	////////////////////
	// Buffer sizing

	// Both depths must be powers of two for the wrap bit pointers
	localparam int WORD_DEPTH = 512;
	localparam int HDR_DEPTH  = 16;

	// Pointer widths without the wrap bit
	localparam int WORD_AW = $clog2(WORD_DEPTH);
	localparam int HDR_AW  = $clog2(HDR_DEPTH);

endpackage

//--- logic/wb_regs_pkg.sv
package wb_regs_pkg;

	////////////////////
	// Wishbone widths

	// Byte address within the slave window
	typedef logic [11:0] wb_addr_t;

	// Read and write data
	typedef logic [31:0] wb_data_t;

	////////////////////
	// Register map

	// Bit 0 is link up, read only
	localparam wb_addr_t REG_STAT    = 12'h000;
	// Any write sends the frame built so far
	localparam wb_addr_t REG_COMMIT  = 12'h020;
	// Bits 10:0 give the expected frame length in bytes
	localparam wb_addr_t REG_LENGTH  = 12'h040;
	// Sequential push of up to 4 of the remaining bytes
	localparam wb_addr_t REG_TX_WORD = 12'h060;
	// Start of the push window
	// Byte offset in the frame is the address minus this base
	localparam wb_addr_t REG_TX_BUF  = 12'h080;

endpackage

//--- logic/frame_push_if.sv
`timescale 1ns/10ps

interface frame_push_if;

	import eth_tx_pkg::*;

	// Word push strobe with the swapped data and its valid byte count
	logic      push;
	word_t     word;
	byte_cnt_t bytes;

	// Frame commit strobe and the announced length in words
	logic      commit;
	word_cnt_t commit_words;

	// Word FIFO cannot take another entry
	logic      full;

	// Register decode side
	modport writer (
		output push, word, bytes, commit, commit_words,
		input  full
	);

	// FIFO side
	modport buffer (
		input  push, word, bytes, commit, commit_words,
		output full
	);

endinterface

//--- logic/frame_pop_if.sv
`timescale 1ns/10ps

interface frame_pop_if;

	import eth_tx_pkg::*;

	// Head of the frame length FIFO
	logic      hdr_valid;
	word_cnt_t hdr_words;
	logic      hdr_pop;

	// Head of the word FIFO, shown while not empty
	word_t     word;
	byte_cnt_t bytes;
	logic      word_pop;

	// FIFO side
	modport buffer (
		output hdr_valid, hdr_words, word, bytes,
		input  hdr_pop, word_pop
	);

	// Transmit FSM side
	modport sender (
		input  hdr_valid, hdr_words, word, bytes,
		output hdr_pop, word_pop
	);

endinterface

//--- logic/wb_frame_writer.sv
`timescale 1ns/10ps

module wb_frame_writer (
	input  logic                  tx_clk,
	input  logic                  rst_n,
	input  logic                  link_up,
	input  logic                  wb_cyc,
	input  logic                  wb_stb,
	input  logic                  wb_we,
	input  wb_regs_pkg::wb_addr_t wb_adr,
	input  wb_regs_pkg::wb_data_t wb_dat_w,
	output wb_regs_pkg::wb_data_t wb_dat_r,
	output logic                  wb_ack,
	output logic                  wb_err,
	frame_push_if.writer          push
);

	import eth_tx_pkg::*;
	import wb_regs_pkg::*;

	// Length state for the frame being built
	frame_len_t exp_len;
	frame_len_t remaining;

	// Request decode
	logic      req;
	logic      is_stat;
	logic      is_commit;
	logic      is_length;
	logic      is_word;
	logic      is_win;
	logic      bad;
	logic      stall;

	// Push decode
	wb_addr_t  win_off;
	wb_addr_t  win_left;
	logic      word_push;
	byte_cnt_t word_bytes;

	////////////////////
	// Address decode

	// New request only while no answer is on the bus
	assign req = wb_cyc && wb_stb && !wb_ack && !wb_err;

	assign is_stat   = (wb_adr == REG_STAT);
	assign is_commit = (wb_adr == REG_COMMIT);
	assign is_length = (wb_adr == REG_LENGTH);
	assign is_word   = (wb_adr == REG_TX_WORD);
	assign is_win    = (wb_adr >= REG_TX_BUF);

	// Byte offset into the frame and bytes left from there
	assign win_off  = wb_adr - REG_TX_BUF;
	assign win_left = {1'b0, exp_len} - win_off;

	// Status is read only and the only readable register
	assign bad = wb_we ? (is_stat || !(is_commit || is_length || is_word || is_win))
		: !is_stat;

	// Valid bytes in this word
	// Words past the frame end are answered but not pushed
	always_comb begin
		word_push  = 1'b0;
		word_bytes = '0;
		if (wb_we && is_word) begin
			if (remaining >= frame_len_t'(4)) begin
				word_push  = 1'b1;
				word_bytes = 3'd4;
			end else if (remaining != '0) begin
				word_push  = 1'b1;
				word_bytes = remaining[2:0];
			end
		end else if (wb_we && is_win) begin
			if (win_off < {1'b0, exp_len}) begin
				word_push  = 1'b1;
				word_bytes = (win_left >= wb_addr_t'(4)) ? 3'd4 : win_left[2:0];
			end
		end
	end

	// Hold the answer while the word FIFO has no room
	assign stall = word_push && push.full;

	////////////////////
	// Bus answer and control

	always_ff @(posedge tx_clk) begin
		if (!rst_n) begin
			wb_ack      <= 1'b0;
			wb_err      <= 1'b0;
			push.push   <= 1'b0;
			push.commit <= 1'b0;
			exp_len     <= '0;
			remaining   <= '0;
		end else begin
			wb_ack      <= req && !bad && !stall;
			wb_err      <= req && bad;
			push.push   <= req && word_push && !stall;
			push.commit <= req && wb_we && is_commit;

			if (req && wb_we && is_length) begin
				exp_len   <= wb_dat_w[10:0];
				remaining <= wb_dat_w[10:0];
			end else if (req && wb_we && is_commit) begin
				// Frame handed over so start clean
				exp_len   <= '0;
				remaining <= '0;
			end else if (req && is_word && word_push && !stall) begin
				remaining <= remaining - frame_len_t'(word_bytes);
			end
		end
	end

	// Payload registers
	always_ff @(posedge tx_clk) begin
		// Host writes little endian, MAC sends first byte in the top lane
		push.word  <= {wb_dat_w[7:0], wb_dat_w[15:8], wb_dat_w[23:16], wb_dat_w[31:24]};
		push.bytes <= word_bytes;
		// Ceiling of the byte length over 4
		push.commit_words <= word_cnt_t'(exp_len[10:2]) + word_cnt_t'(|exp_len[1:0]);
		wb_dat_r <= (req && !wb_we && is_stat) ? wb_data_t'(link_up) : '0;
	end

endmodule

//--- logic/tx_frame_buffer.sv
`timescale 1ns/10ps

module tx_frame_buffer (
	input  logic          tx_clk,
	input  logic          rst_n,
	input  logic          link_up,
	frame_push_if.buffer  push,
	frame_pop_if.buffer   pop
);

	import eth_tx_pkg::*;

	////////////////////
	// Storage

	// Word FIFO keeps data and byte count side by side
	word_t     word_mem  [WORD_DEPTH];
	byte_cnt_t bytes_mem [WORD_DEPTH];

	// Frame length FIFO in words
	word_cnt_t hdr_mem [HDR_DEPTH];

	// Pointers carry one extra wrap bit
	logic [WORD_AW:0] word_wr_ptr;
	logic [WORD_AW:0] word_rd_ptr;
	logic [HDR_AW:0]  hdr_wr_ptr;
	logic [HDR_AW:0]  hdr_rd_ptr;

	logic word_full;
	logic word_empty;
	logic hdr_full;
	logic hdr_empty;
	logic word_wr;
	logic word_rd;
	logic hdr_wr;
	logic hdr_rd;

	////////////////////
	// Flags

	assign word_empty = (word_wr_ptr == word_rd_ptr);
	assign word_full  = (word_wr_ptr[WORD_AW] != word_rd_ptr[WORD_AW]) &&
		(word_wr_ptr[WORD_AW-1:0] == word_rd_ptr[WORD_AW-1:0]);
	assign hdr_empty  = (hdr_wr_ptr == hdr_rd_ptr);
	assign hdr_full   = (hdr_wr_ptr[HDR_AW] != hdr_rd_ptr[HDR_AW]) &&
		(hdr_wr_ptr[HDR_AW-1:0] == hdr_rd_ptr[HDR_AW-1:0]);

	// Writes and reads that actually move a pointer
	assign word_wr = push.push && !word_full;
	assign word_rd = pop.word_pop && !word_empty;
	// A commit with no room for its header is dropped
	assign hdr_wr  = push.commit && !hdr_full;
	assign hdr_rd  = pop.hdr_pop && !hdr_empty;

	assign push.full = word_full;

	////////////////////
	// Pointers

	// Link down flushes both FIFOs every cycle
	always_ff @(posedge tx_clk) begin
		if (!rst_n || !link_up) begin
			word_wr_ptr <= '0;
			word_rd_ptr <= '0;
			hdr_wr_ptr  <= '0;
			hdr_rd_ptr  <= '0;
		end else begin
			if (word_wr)
				word_wr_ptr <= word_wr_ptr + 1'b1;
			if (word_rd)
				word_rd_ptr <= word_rd_ptr + 1'b1;
			if (hdr_wr)
				hdr_wr_ptr <= hdr_wr_ptr + 1'b1;
			if (hdr_rd)
				hdr_rd_ptr <= hdr_rd_ptr + 1'b1;
		end
	end

	////////////////////
	// Memory writes

	always_ff @(posedge tx_clk) begin
		if (word_wr) begin
			word_mem[word_wr_ptr[WORD_AW-1:0]]  <= push.word;
			bytes_mem[word_wr_ptr[WORD_AW-1:0]] <= push.bytes;
		end
		if (hdr_wr)
			hdr_mem[hdr_wr_ptr[HDR_AW-1:0]] <= push.commit_words;
	end

	// Heads are read straight from the memories
	assign pop.word      = word_mem[word_rd_ptr[WORD_AW-1:0]];
	assign pop.bytes     = bytes_mem[word_rd_ptr[WORD_AW-1:0]];
	assign pop.hdr_words = hdr_mem[hdr_rd_ptr[HDR_AW-1:0]];
	assign pop.hdr_valid = !hdr_empty;

endmodule

//--- logic/tx_frame_sender.sv
`timescale 1ns/10ps

module tx_frame_sender (
	input  logic                  tx_clk,
	input  logic                  rst_n,
	frame_pop_if.sender           pop,
	output logic                  tx_start,
	output logic                  tx_data_valid,
	output eth_tx_pkg::byte_cnt_t tx_bytes_valid,
	output eth_tx_pkg::word_t     tx_data
);

	import eth_tx_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_POP,
		ST_SENDING
	} state_t;

	state_t    state;

	// Words still to pop in this frame
	word_cnt_t left;

	////////////////////
	// FIFO handshakes

	// Header goes as soon as it shows up in idle
	assign pop.hdr_pop  = (state == ST_IDLE) && pop.hdr_valid;

	// One word per cycle for the whole frame
	assign pop.word_pop = (state == ST_POP) || (state == ST_SENDING);

	////////////////////
	// Frame FSM

	always_ff @(posedge tx_clk) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			left  <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					left <= pop.hdr_words;
					// Empty frames are popped and skipped
					if (pop.hdr_valid && (pop.hdr_words != '0))
						state <= ST_POP;
				end
				ST_POP, ST_SENDING: begin
					left <= left - 1'b1;
					if (left == word_cnt_t'(1))
						state <= ST_IDLE;
					else
						state <= ST_SENDING;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	////////////////////
	// Output register

	always_ff @(posedge tx_clk) begin
		if (!rst_n) begin
			tx_start      <= 1'b0;
			tx_data_valid <= 1'b0;
		end else begin
			// First popped word marks the frame start
			tx_start      <= (state == ST_POP);
			tx_data_valid <= pop.word_pop;
		end
	end

	always_ff @(posedge tx_clk) begin
		tx_data        <= pop.word;
		tx_bytes_valid <= pop.bytes;
	end

endmodule

//--- logic/eth_tx_buffer_top.sv
`timescale 1ns/10ps

module eth_tx_buffer_top (
	input  logic                  tx_clk,
	input  logic                  rst_n,

	// Wishbone slave
	input  logic                  wb_cyc,
	input  logic                  wb_stb,
	input  logic                  wb_we,
	input  wb_regs_pkg::wb_addr_t wb_adr,
	input  wb_regs_pkg::wb_data_t wb_dat_w,
	output wb_regs_pkg::wb_data_t wb_dat_r,
	output logic                  wb_ack,
	output logic                  wb_err,

	// MAC status
	input  logic                  link_up,

	// MAC transmit bus
	output logic                  tx_start,
	output logic                  tx_data_valid,
	output eth_tx_pkg::byte_cnt_t tx_bytes_valid,
	output eth_tx_pkg::word_t     tx_data
);

	////////////////////
	// Internal buses

	frame_push_if push_bus ();
	frame_pop_if  pop_bus ();

	////////////////////
	// Blocks

	// Register decode and word push
	wb_frame_writer u_writer (
		.tx_clk   (tx_clk),
		.rst_n    (rst_n),
		.link_up  (link_up),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack),
		.wb_err   (wb_err),
		.push     (push_bus.writer)
	);

	// Word and length FIFOs
	tx_frame_buffer u_buffer (
		.tx_clk  (tx_clk),
		.rst_n   (rst_n),
		.link_up (link_up),
		.push    (push_bus.buffer),
		.pop     (pop_bus.buffer)
	);

	// Frame streaming onto the MAC bus
	tx_frame_sender u_sender (
		.tx_clk         (tx_clk),
		.rst_n          (rst_n),
		.pop            (pop_bus.sender),
		.tx_start       (tx_start),
		.tx_data_valid  (tx_data_valid),
		.tx_bytes_valid (tx_bytes_valid),
		.tx_data        (tx_data)
	);

endmodule

//--- tests/eth_tx_buffer_chk.sv
`timescale 1ns/10ps

module eth_tx_buffer_chk (
	input logic                  tx_clk,
	input logic                  rst_n,
	input logic                  wb_cyc,
	input logic                  wb_stb,
	input logic                  wb_ack,
	input logic                  wb_err,
	input logic                  tx_start,
	input logic                  tx_data_valid,
	input eth_tx_pkg::byte_cnt_t tx_bytes_valid
);

	// Assertion failures seen so far
	int fail_count = 0;

	////////////////////
	// Wishbone answer

	// One kind of answer per cycle
	ack_err_excl: assert property (@(posedge tx_clk) disable iff (!rst_n)
		!(wb_ack && wb_err)) else begin
		fail_count++;
		$error("wb_ack and wb_err high together");
	end

	// Answers only inside an open cycle
	answer_in_cycle: assert property (@(posedge tx_clk) disable iff (!rst_n)
		(wb_ack || wb_err) |-> (wb_cyc && wb_stb)) else begin
		fail_count++;
		$error("wb answer without cyc and stb");
	end

	////////////////////
	// Transmit bus

	start_has_data: assert property (@(posedge tx_clk) disable iff (!rst_n)
		tx_start |-> tx_data_valid) else begin
		fail_count++;
		$error("tx_start without tx_data_valid");
	end

	// An empty beat is never sent
	bytes_nonzero: assert property (@(posedge tx_clk) disable iff (!rst_n)
		tx_data_valid |-> (tx_bytes_valid != '0)) else begin
		fail_count++;
		$error("tx_bytes_valid is zero on a valid beat");
	end

endmodule

bind eth_tx_buffer_top eth_tx_buffer_chk u_chk (.*);

//--- tests/tb_clkgen.sv
`timescale 1ns/10ps

module tb_clkgen (
	output logic tx_clk,
	output logic rst_n
);

	// Cycles of reset after time zero
	localparam int RESET_CYCLES = 5;

	// 20 ns period
	initial begin
		tx_clk = 1'b0;
		forever #10 tx_clk = ~tx_clk;
	end

	// Released 2 ns after the edge like the other inputs
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge tx_clk);
		#2 rst_n = 1'b1;
	end

endmodule

//--- tests/eth_tx_buffer_tb.sv
`timescale 1ns/10ps

module eth_tx_buffer_tb;

	import eth_tx_pkg::*;
	import wb_regs_pkg::*;

	// Frames per test; the last four are three flushed ones and one after link up
	localparam int N_SEQ = 8;
	localparam int N_WIN = 6;
	localparam int N_QUE = 6;
	localparam int N_ALL = N_SEQ + N_WIN + N_QUE + 4;

	logic      tx_clk;
	logic      rst_n;
	logic      wb_cyc;
	logic      wb_stb;
	logic      wb_we;
	wb_addr_t  wb_adr;
	wb_data_t  wb_dat_w;
	wb_data_t  wb_dat_r;
	logic      wb_ack;
	logic      wb_err;
	logic      link_up;
	logic      tx_start;
	logic      tx_data_valid;
	byte_cnt_t tx_bytes_valid;
	word_t     tx_data;

	// Model beats and collected beats
	word_t      exp_data[$];
	byte_cnt_t  exp_bytes[$];
	logic       exp_start[$];
	word_t      rx_data[$];
	byte_cnt_t  rx_bytes[$];
	logic       rx_start[$];
	frame_len_t lens[N_ALL];

	int   checked = 0;
	int   errors = 0;
	int   stalls = 0;
	int   tests = 0;
	int   failed_tests = 0;
	int   assert_seen = 0;
	int   cycles = 0;
	int   cycle_limit = 1000000;
	logic prev_valid = 1'b0;

	tb_clkgen u_clkgen (.tx_clk(tx_clk), .rst_n(rst_n));

	eth_tx_buffer_top DUT (.*);

	////////////////////
	// Compare tasks

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			errors++;
			$display("MISMATCH %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_bytes(input string name, input byte_cnt_t got, input byte_cnt_t exp);
		if (got !== exp) begin
			errors++;
			$display("MISMATCH %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_data(input string name, input wb_data_t got, input wb_data_t exp);
		if (got !== exp) begin
			errors++;
			$display("MISMATCH %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			errors++;
			$display("MISMATCH %s: got %h expected %h", name, got, exp);
		end
	endtask

	////////////////////
	// Wishbone master

	// One classic cycle, held until ack or err
	task automatic bus_access(input logic we, input wb_addr_t adr, input wb_data_t dat,
		output wb_data_t rdat, output logic err);
		int waits;
		@(posedge tx_clk);
		#2;
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = dat;
		waits    = 0;
		do begin
			@(negedge tx_clk);
			waits++;
		end while (!wb_ack && !wb_err);
		// More than one wait means the buffer held the ack back
		if (waits > 1)
			stalls++;
		rdat = wb_dat_r;
		err  = wb_err;
		@(posedge tx_clk);
		#2;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic bus_write(input wb_addr_t adr, input wb_data_t dat);
		wb_data_t rdat;
		logic     err;
		bus_access(1'b1, adr, dat, rdat, err);
		if (err) begin
			errors++;
			$display("ERROR: write to address %h was answered with err", adr);
		end
	endtask

	////////////////////
	// Frame model

	// First host byte leaves in the top lane
	function automatic word_t wire_order(input wb_data_t d);
		word_t w;
		for (int b = 0; b < 4; b++)
			w[31-8*b -: 8] = d[8*b +: 8];
		return w;
	endfunction

	// Write one frame and predict its beats unless the link is down
	task automatic send_frame(input frame_len_t len, input logic windowed, input logic keep);
		int       nw;
		int       extra;
		wb_data_t d;
		nw    = (int'(len) + 3) / 4;
		extra = 1 + $urandom % 3;
		bus_write(REG_LENGTH, wb_data_t'(len));
		for (int i = 0; i < nw; i++) begin
			d = $urandom;
			if (windowed)
				bus_write(REG_TX_BUF + wb_addr_t'(4 * i), d);
			else
				bus_write(REG_TX_WORD, d);
			if (keep) begin
				exp_data.push_back(wire_order(d));
				exp_bytes.push_back((i == nw - 1) ? byte_cnt_t'(int'(len) - 4 * i) : 3'd4);
				exp_start.push_back(i == 0);
			end
		end
		// Past the frame end these are answered but dropped
		if (windowed) begin
			for (int k = 0; k < extra; k++)
				bus_write(REG_TX_BUF + wb_addr_t'(4 * (nw + k)), $urandom);
		end
		bus_write(REG_COMMIT, $urandom);
	endtask

	// Wait for the predicted beats, then compare the new ones
	task automatic compare_beats();
		while (rx_data.size() < exp_data.size())
			@(negedge tx_clk);
		while (checked < exp_data.size()) begin
			check_word($sformatf("tx_data[%0d]", checked), rx_data[checked], exp_data[checked]);
			check_bytes($sformatf("tx_bytes_valid[%0d]", checked), rx_bytes[checked],
				exp_bytes[checked]);
			check_flag($sformatf("tx_start[%0d]", checked), rx_start[checked],
				exp_start[checked]);
			checked++;
		end
	endtask

	task automatic end_test(input string name, input int mark);
		// Bound assertion failures count against the test that was running
		errors += DUT.u_chk.fail_count - assert_seen;
		assert_seen = DUT.u_chk.fail_count;
		tests++;
		if (errors == mark) begin
			$display("test %0d %s: ok", tests, name);
		end else begin
			failed_tests++;
			$display("test %0d %s: failed with %0d errors", tests, name, errors - mark);
		end
	endtask

	////////////////////
	// Monitor and watchdog

	// Sampled mid cycle where the registered outputs are stable
	always @(negedge tx_clk) begin
		if (rst_n && tx_data_valid) begin
			if (!tx_start && !prev_valid) begin
				errors++;
				$display("ERROR: frame data resumed without tx_start");
			end
			rx_data.push_back(tx_data);
			rx_bytes.push_back(tx_bytes_valid);
			rx_start.push_back(tx_start);
		end
		prev_valid = rst_n && tx_data_valid;
	end

	always @(posedge tx_clk) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("ERROR: run did not finish within %0d cycles", cycle_limit);
			$display("=== FAIL ===");
			$finish;
		end
	end

	////////////////////
	// Test sequence

	initial begin
		int       seed;
		int       total_words;
		int       mark;
		wb_data_t rdat;
		logic     err;
		seed     = $urandom(60404);
		wb_cyc   = 1'b0;
		wb_stb   = 1'b0;
		wb_we    = 1'b0;
		wb_adr   = '0;
		wb_dat_w = '0;
		link_up  = 1'b1;

		// Lengths up front so the cycle limit follows the work
		total_words = 0;
		foreach (lens[i]) begin
			// One queued frame is long enough to fill the word FIFO
			if (i == N_SEQ + N_WIN + 2)
				lens[i] = frame_len_t'(2047);
			else
				lens[i] = frame_len_t'(1 + $urandom % 200);
			total_words += (int'(lens[i]) + 3) / 4;
		end
		cycle_limit = total_words * 8 + N_ALL * 40 + 2000;

		@(posedge rst_n);
		@(negedge tx_clk);

		// Idle outputs, status read and error answers
		mark = errors;
		check_flag("wb_ack", wb_ack, 1'b0);
		check_flag("wb_err", wb_err, 1'b0);
		check_flag("tx_start", tx_start, 1'b0);
		check_flag("tx_data_valid", tx_data_valid, 1'b0);
		bus_access(1'b0, REG_STAT, '0, rdat, err);
		check_flag("wb_err", err, 1'b0);
		check_data("wb_dat_r", rdat, 32'h1);
		bus_access(1'b1, REG_STAT, $urandom, rdat, err);
		check_flag("wb_err", err, 1'b1);
		bus_access(1'b0, REG_LENGTH, '0, rdat, err);
		check_flag("wb_err", err, 1'b1);
		bus_access(1'b1, 12'h010, $urandom, rdat, err);
		check_flag("wb_err", err, 1'b1);
		end_test("status and errors", mark);

		mark = errors;
		for (int i = 0; i < N_SEQ; i++) begin
			send_frame(lens[i], 1'b0, 1'b1);
			compare_beats();
		end
		end_test("sequential push", mark);

		mark = errors;
		for (int i = N_SEQ; i < N_SEQ + N_WIN; i++) begin
			send_frame(lens[i], 1'b1, 1'b1);
			compare_beats();
		end
		end_test("windowed push", mark);

		// Frames queue up behind each other, one fills the word FIFO
		mark = errors;
		for (int i = N_SEQ + N_WIN; i < N_SEQ + N_WIN + N_QUE; i++)
			send_frame(lens[i], i[0], 1'b1);
		compare_beats();
		end_test($sformatf("queuing, %0d delayed acks", stalls), mark);

		// Link down drops whole frames
		mark = errors;
		@(posedge tx_clk);
		#2 link_up = 1'b0;
		bus_access(1'b0, REG_STAT, '0, rdat, err);
		check_data("wb_dat_r", rdat, 32'h0);
		for (int i = N_ALL - 4; i < N_ALL - 1; i++)
			send_frame(lens[i], i[0], 1'b0);
		repeat (3) @(posedge tx_clk);
		#2 link_up = 1'b1;
		send_frame(lens[N_ALL - 1], 1'b0, 1'b1);
		compare_beats();
		repeat (20) @(negedge tx_clk);
		if (rx_data.size() != exp_data.size()) begin
			errors++;
			$display("ERROR: %0d words sent beyond the expected frames",
				rx_data.size() - exp_data.size());
		end
		end_test("link-down flush", mark);

		$display("tests %0d, failed %0d, failed checks %0d, words %0d",
			tests, failed_tests, errors, rx_data.size());
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

//--- vlog.f
logic/eth_tx_pkg.sv
logic/wb_regs_pkg.sv
logic/frame_push_if.sv
logic/frame_pop_if.sv
logic/wb_frame_writer.sv
logic/tx_frame_buffer.sv
logic/tx_frame_sender.sv
logic/eth_tx_buffer_top.sv
tests/eth_tx_buffer_chk.sv
tests/tb_clkgen.sv
tests/eth_tx_buffer_tb.sv

//--- Bender.yml
package:
  name: eth_tx_buffer

sources:
  - logic/eth_tx_pkg.sv
  - logic/wb_regs_pkg.sv
  - logic/frame_push_if.sv
  - logic/frame_pop_if.sv
  - logic/wb_frame_writer.sv
  - logic/tx_frame_buffer.sv
  - logic/tx_frame_sender.sv
  - logic/eth_tx_buffer_top.sv
  - target: test
    files:
      - tests/eth_tx_buffer_chk.sv
      - tests/tb_clkgen.sv
      - tests/eth_tx_buffer_tb.sv
